/* run_sim.sh */
#!/bin/sh
# build the divider testbench with Verilator, run it, read the verdict from the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_int_div -o tb_int_div -f vlog.f > "$LOG" 2>&1 &&
  ./obj_dir/tb_int_div +verilator+error+limit+1000 >> "$LOG" 2>&1
cat "$LOG"
grep -qx "TEST PASS" "$LOG" && echo "simulation passed" && exit 0 ||
  { echo "simulation failed, see $LOG"; exit 1; }

/* sim/div_checker.sv */
/*
 * scoreboard for the divider that watches both handshakes
 * models each accepted request, compares and counts errors
 */
`default_nettype none

module div_checker #(
  parameter int WIDTH = 32
) (
  input  logic                 clk,
  input  logic                 reset,
  input  imuldiv_pkg::div_fn_e req_fn,
  input  logic [WIDTH-1:0]     req_a,
  input  logic [WIDTH-1:0]     req_b,
  input  logic                 req_val,
  input  logic                 req_rdy,
  input  logic [2*WIDTH-1:0]   resp_result,
  input  logic                 resp_val,
  input  logic                 resp_rdy,
  input  logic                 end_of_test,
  output int                   err_count,
  output int                   resp_count
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [WIDTH-1:0] MOST_NEG = {1'b1, {(WIDTH-1){1'b0}}};

  // ----------------------------------------
  // reference model
  // ----------------------------------------

  // remainder in the upper half and quotient in the lower half
  function automatic logic [2*WIDTH-1:0] expected_result(
    input imuldiv_pkg::div_fn_e fn,
    input logic [WIDTH-1:0]     a,
    input logic [WIDTH-1:0]     b
  );
    logic [WIDTH-1:0]        quo;
    logic [WIDTH-1:0]        rem;
    logic signed [WIDTH-1:0] sa;
    logic signed [WIDTH-1:0] sb;
    sa = $signed(a);
    sb = $signed(b);
    if (b == '0) begin
      // zero divisor gives an all ones quotient and the dividend back
      quo = '1;
      rem = a;
    end else if (fn == imuldiv_pkg::FN_UNSIGNED) begin
      quo = a / b;
      rem = a % b;
    end else if (a == MOST_NEG && b == '1) begin
      // the one signed overflow case wraps to itself
      quo = MOST_NEG;
      rem = '0;
    end else begin
      // truncates toward zero and the remainder takes the dividend's sign
      quo = $unsigned(sa / sb);
      rem = $unsigned(sa % sb);
    end
    return {rem, quo};
  endfunction

  // ----------------------------------------
  // monitor
  // ----------------------------------------

  logic [2*WIDTH-1:0] expected_q[$];
  logic [2*WIDTH-1:0] expected;
  logic [2*WIDTH-1:0] held_result;
  logic               stalled;
  logic               end_seen;

  // sampled on the falling edge where inputs are settled for the next rising edge
  always @(negedge clk) begin
    if (reset) begin
      expected_q.delete();
      err_count  = 0;
      resp_count = 0;
      stalled    = 1'b0;
      end_seen   = 1'b0;
    end else begin
      // stalled response must keep its value
      if (stalled && resp_val && resp_result !== held_result) begin
        err_count++;
        $display("[FAIL] %0t: result moved under back-pressure, %h then %h",
                 $time, held_result, resp_result);
      end
      if (req_val && req_rdy) begin
        expected_q.push_back(expected_result(req_fn, req_a, req_b));
      end
      if (resp_val && resp_rdy) begin
        if (expected_q.size() == 0) begin
          err_count++;
          $display("extra response at time %0t with no request outstanding", $time);
        end else begin
          expected = expected_q.pop_front();
          if (resp_result !== expected) begin
            err_count++;
            $display("[FAIL] %0t: response %0d is %h, expected %h",
                     $time, resp_count, resp_result, expected);
          end
          resp_count++;
        end
      end
      stalled     = resp_val && !resp_rdy;
      held_result = resp_result;
      // anything still queued at the end never got its answer
      if (end_of_test && !end_seen) begin
        end_seen = 1'b1;
        if (expected_q.size() != 0) begin
          err_count++;
          $display("missing responses: %0d accepted requests were never answered",
                   expected_q.size());
        end
      end
    end
  end

endmodule

`default_nettype wire

/* sim/div_props.sv */
/*
 * concurrent assertions on the divider control FSM
 * handshake exclusion, back-pressure hold, return to idle, fixed latency
 */
`default_nettype none

module div_props #(
  parameter int WIDTH = 32
) (
  input logic                    clk,
  input logic                    reset,
  input imuldiv_pkg::div_state_e state,
  input logic                    req_rdy,
  input logic                    resp_val,
  input logic                    resp_rdy,
  input logic                    load
);
  timeunit 1ns;
  timeprecision 1ps;

  // number of assertion failures so far
  int fail_count = 0;

  // request and response side never ready at once
  rdy_val_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(req_rdy && resp_val))
    else begin
      fail_count++;
      $error("req_rdy and resp_val high in the same cycle");
    end

  // a stalled response stays valid
  resp_held: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> resp_val)
    else begin
      fail_count++;
      $error("resp_val dropped while resp_rdy was low");
    end

  // the edge that takes the response puts the FSM back in idle
  resp_to_idle: assert property (@(posedge clk) disable iff (reset)
    (resp_val && resp_rdy) |=> (state == imuldiv_pkg::ST_IDLE))
    else begin
      fail_count++;
      $error("control did not return to idle after the response was taken");
    end

  // resp_val rises exactly WIDTH cycles after the accepting edge
  latency: assert property (@(posedge clk) disable iff (reset)
    $past(load, WIDTH + 1) == $rose(resp_val))
    else begin
      fail_count++;
      $error("resp_val did not rise WIDTH cycles after the accept");
    end

endmodule

bind int_div_ctrl div_props #(
  .WIDTH    (WIDTH)
) props (
  .clk      (clk),
  .reset    (reset),
  .state    (state),
  .req_rdy  (req_rdy),
  .resp_val (resp_val),
  .resp_rdy (resp_rdy),
  .load     (load)
);

`default_nettype wire

/* sim/tb_int_div.sv */
/*
 * testbench top for the iterative divider
 * clock, reset, LCG request stimulus with back-pressure, timeout and closing report
 */
`default_nettype none

module tb_int_div;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WIDTH      = imuldiv_pkg::DIV_WIDTH;
  localparam int NUM_REQ    = 300;
  localparam int MAX_CYCLES = NUM_REQ * (WIDTH + 1) * 4 + 20;
  localparam logic [WIDTH-1:0] MOST_NEG = {1'b1, {(WIDTH-1){1'b0}}};

  logic                 clk;
  logic                 reset;
  imuldiv_pkg::div_fn_e req_fn;
  logic [WIDTH-1:0]     req_a;
  logic [WIDTH-1:0]     req_b;
  logic                 req_val;
  logic                 req_rdy;
  logic [2*WIDTH-1:0]   resp_result;
  logic                 resp_val;
  logic                 resp_rdy;
  logic                 end_of_test;

  int          err_count;
  int          resp_count;
  int          reset_errors;
  int          timeouts;
  int          cycle_count;
  logic [31:0] lcg_state;

  int_div_iterative #(
    .WIDTH       (WIDTH)
  ) UUT (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  div_checker #(
    .WIDTH       (WIDTH)
  ) result_check (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .end_of_test (end_of_test),
    .err_count   (err_count),
    .resp_count  (resp_count)
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // ----------------------------------------
  // stimulus helpers
  // ----------------------------------------

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // corner values mixed in with random words
  function automatic logic [WIDTH-1:0] pick_operand(
    input logic [2:0]  kind,
    input logic [31:0] word
  );
    case (kind)
      3'd0:    return '0;
      3'd1:    return {{(WIDTH-1){1'b0}}, 1'b1};
      3'd2:    return '1;
      3'd3:    return MOST_NEG;
      3'd4:    return WIDTH'(word[15:0]);
      3'd5:    return ~WIDTH'(word[7:0]);
      default: return WIDTH'(word);
    endcase
  endfunction

  // first four requests are fixed corner cases
  task automatic drive_request(input int index);
    logic [31:0] kinds;
    logic [31:0] word_a;
    logic [31:0] word_b;
    lcg_state = lcg(lcg_state);
    kinds     = lcg_state;
    lcg_state = lcg(lcg_state);
    word_a    = lcg_state;
    lcg_state = lcg(lcg_state);
    word_b    = lcg_state;
    req_val   = 1'b1;
    case (index)
      0: begin
        req_fn = imuldiv_pkg::FN_SIGNED;
        req_a  = MOST_NEG;
        req_b  = '1;
      end
      1: begin
        req_fn = imuldiv_pkg::FN_UNSIGNED;
        req_a  = MOST_NEG;
        req_b  = '1;
      end
      2: begin
        req_fn = imuldiv_pkg::FN_SIGNED;
        req_a  = MOST_NEG;
        req_b  = '0;
      end
      3: begin
        req_fn = imuldiv_pkg::FN_UNSIGNED;
        req_a  = WIDTH'(word_a);
        req_b  = '0;
      end
      default: begin
        req_fn = kinds[31] ? imuldiv_pkg::FN_SIGNED : imuldiv_pkg::FN_UNSIGNED;
        req_a  = pick_operand(kinds[30:28], word_a);
        req_b  = pick_operand(kinds[27:25], word_b);
      end
    endcase
  endtask

  task automatic finish_run();
    int total;
    total = err_count + reset_errors + timeouts + UUT.ctrl.props.fail_count;
    $display("error counts: checker %0d, reset %0d, assertion %0d, timeout %0d",
             err_count, reset_errors, UUT.ctrl.props.fail_count, timeouts);
    if (total == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin : stimulus
    int   sent;
    int   gap;
    logic offer_taken;
    reset        = 1'b1;
    req_fn       = imuldiv_pkg::FN_UNSIGNED;
    req_a        = '0;
    req_b        = '0;
    req_val      = 1'b0;
    resp_rdy     = 1'b0;
    end_of_test  = 1'b0;
    reset_errors = 0;
    lcg_state    = 32'd83;
    sent         = 0;
    gap          = 0;
    offer_taken  = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;
    // idle with request side open
    @(negedge clk);
    if (req_rdy !== 1'b1 || resp_val !== 1'b0) begin
      reset_errors++;
      $display("[FAIL] %0t: after reset req_rdy=%b resp_val=%b, expected 1 and 0",
               $time, req_rdy, resp_val);
    end
    while (resp_count < NUM_REQ) begin
      @(posedge clk);
      #2;
      // request went in on the edge just passed
      if (offer_taken) begin
        req_val   = 1'b0;
        sent++;
        lcg_state = lcg(lcg_state);
        gap       = lcg_state[31] ? 0 : int'(lcg_state[30:29]) + 1;
      end
      // back-pressure about one cycle in four
      lcg_state = lcg(lcg_state);
      resp_rdy  = (lcg_state[31:30] != 2'b00);
      if (!req_val && sent < NUM_REQ) begin
        if (gap == 0) begin
          drive_request(sent);
        end else begin
          gap--;
        end
      end
      // req_rdy follows the state only
      offer_taken = req_val && req_rdy;
    end
    // catch a stray response after the last one
    resp_rdy = 1'b1;
    repeat (2 * WIDTH) @(posedge clk);
    #2;
    end_of_test = 1'b1;
    @(posedge clk);
    finish_run();
  end

  // cycle limit
  initial begin : watchdog
    timeouts    = 0;
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    timeouts = 1;
    $display("run timed out after %0d cycles with %0d of %0d responses seen",
             cycle_count, resp_count, NUM_REQ);
    finish_run();
  end

endmodule

`default_nettype wire

/* src/imuldiv_pkg.sv */
/*
 * shared definitions for the iterative divider
 * default operand width, request function codes, control state encoding
 */
`default_nettype none

package imuldiv_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------

  // default operand width
  // the top level hands this down as WIDTH
  // the result word is twice this wide
  localparam int DIV_WIDTH = 32;

  // ----------------------------------------
  // request function
  // ----------------------------------------

  // one bit travels with every request
  // unsigned takes both operands as plain binary
  // signed takes both operands as two's complement
  typedef enum logic [0:0] {
    FN_UNSIGNED = 1'b0,
    FN_SIGNED   = 1'b1
  } div_fn_e;

  // ----------------------------------------
  // control state
  // ----------------------------------------

  // idle: waiting for a request, req_rdy high
  // calc: one restoring step per cycle, WIDTH cycles
  // done: result held on the response port until taken
  // the fourth code is never entered
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } div_state_e;

endpackage

`default_nettype wire

/* src/int_div_ctrl.sv */
/*
 * divider control: idle/calc/done FSM, iteration counter,
 * val/rdy handshake on request and response
 */
`default_nettype none

module int_div_ctrl #(
  parameter int WIDTH = 32
) (
  input  logic clk,
  input  logic reset,

  // handshake with the outside
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,

  // to the datapath
  output logic load,
  output logic step
);

  // ----------------------------------------
  // iteration counter sizing
  // ----------------------------------------

  // counts 0 .. WIDTH-1, one per calc cycle
  localparam int CNT_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;
  localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(WIDTH - 1);

  imuldiv_pkg::div_state_e state;
  imuldiv_pkg::div_state_e state_next;
  logic [CNT_W-1:0]        count;

  logic req_fire;
  logic resp_fire;
  logic last_step;

  // ----------------------------------------
  // outputs from state
  // ----------------------------------------

  assign req_rdy   = (state == imuldiv_pkg::ST_IDLE);
  assign resp_val  = (state == imuldiv_pkg::ST_DONE);
  assign step      = (state == imuldiv_pkg::ST_CALC);

  // a request is taken on the edge where both are high
  assign req_fire  = req_rdy && req_val;
  assign resp_fire = resp_val && resp_rdy;
  assign load      = req_fire;

  assign last_step = (count == LAST_STEP);

  // ----------------------------------------
  // next state
  // ----------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      imuldiv_pkg::ST_IDLE: begin
        if (req_fire) begin
          state_next = imuldiv_pkg::ST_CALC;
        end
      end
      imuldiv_pkg::ST_CALC: begin
        // leave after the WIDTH-th step
        if (last_step) begin
          state_next = imuldiv_pkg::ST_DONE;
        end
      end
      imuldiv_pkg::ST_DONE: begin
        // hold the result as long as the consumer stalls
        if (resp_fire) begin
          state_next = imuldiv_pkg::ST_IDLE;
        end
      end
      default: begin
        state_next = imuldiv_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // ----------------------------------------
  // iteration counter
  // ----------------------------------------

  // cleared on accept, advanced once per step
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (load) begin
      count <= '0;
    end else if (step) begin
      count <= count + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* src/int_div_dpath.sv */
/*
 * divider datapath: operand, remainder and quotient registers,
 * one restoring step per cycle, sign and divide-by-zero correction
 */
`default_nettype none

module int_div_dpath #(
  parameter int WIDTH = 32
) (
  input  logic                      clk,
  input  logic                      reset,

  // request payload, sampled on load
  input  imuldiv_pkg::div_fn_e      req_fn,
  input  logic [WIDTH-1:0]          req_a,
  input  logic [WIDTH-1:0]          req_b,

  // from control
  input  logic                      load,
  input  logic                      step,

  // remainder in the upper half, quotient in the lower half
  output logic [2*WIDTH-1:0]        resp_result
);

  // ----------------------------------------
  // magnitude helper
  // ----------------------------------------

  // negate only when signed and the sign bit is set
  function automatic logic [WIDTH-1:0] magnitude(
    input imuldiv_pkg::div_fn_e fn,
    input logic [WIDTH-1:0]     value
  );
    logic neg;
    neg = (fn == imuldiv_pkg::FN_SIGNED) && value[WIDTH-1];
    return neg ? (~value + 1'b1) : value;
  endfunction

  // ----------------------------------------
  // registers
  // ----------------------------------------

  // request attributes kept for the output correction
  imuldiv_pkg::div_fn_e fn_q;
  logic                 a_sign_q;
  logic                 b_sign_q;
  logic                 b_zero_q;

  // partial remainder
  logic [WIDTH-1:0]     rem_q;
  // dividend shifts out the top while quotient bits shift in below
  logic [WIDTH-1:0]     quo_q;
  // divisor magnitude, constant during the iterations
  logic [WIDTH-1:0]     divisor_q;

  // ----------------------------------------
  // restoring step
  // ----------------------------------------

  // remainder and next dividend bit, one bit wider than the operands
  logic [WIDTH:0]       shifted;
  // trial difference, extra top bit is the borrow
  logic [WIDTH+1:0]     diff;
  logic                 diff_neg;

  assign shifted  = {rem_q, quo_q[WIDTH-1]};
  assign diff     = {1'b0, shifted} - {2'b00, divisor_q};
  // negative means the divisor did not fit, so keep the shifted value
  assign diff_neg = diff[WIDTH+1];

  // attributes of the request in flight
  always_ff @(posedge clk) begin
    if (reset) begin
      fn_q     <= imuldiv_pkg::FN_UNSIGNED;
      a_sign_q <= 1'b0;
      b_sign_q <= 1'b0;
      b_zero_q <= 1'b0;
    end else if (load) begin
      fn_q     <= req_fn;
      a_sign_q <= req_a[WIDTH-1];
      b_sign_q <= req_b[WIDTH-1];
      b_zero_q <= (req_b == '0);
    end
  end

  // operand and iteration registers
  always_ff @(posedge clk) begin
    if (load) begin
      rem_q     <= '0;
      quo_q     <= magnitude(req_fn, req_a);
      divisor_q <= magnitude(req_fn, req_b);
    end else if (step) begin
      if (diff_neg) begin
        // restore: keep the shifted remainder, quotient bit 0
        rem_q <= shifted[WIDTH-1:0];
        quo_q <= {quo_q[WIDTH-2:0], 1'b0};
      end else begin
        // divisor fits: keep the difference, quotient bit 1
        rem_q <= diff[WIDTH-1:0];
        quo_q <= {quo_q[WIDTH-2:0], 1'b1};
      end
    end
  end

  // ----------------------------------------
  // result correction
  // ----------------------------------------

  logic             quo_neg;
  logic             rem_neg;
  logic [WIDTH-1:0] quo_out;
  logic [WIDTH-1:0] rem_out;

  // quotient sign: exactly one operand negative
  // remainder follows the sign of the dividend
  assign quo_neg = (fn_q == imuldiv_pkg::FN_SIGNED) && (a_sign_q ^ b_sign_q);
  assign rem_neg = (fn_q == imuldiv_pkg::FN_SIGNED) && a_sign_q;

  always_comb begin
    rem_out = rem_neg ? (~rem_q + 1'b1) : rem_q;
    quo_out = quo_neg ? (~quo_q + 1'b1) : quo_q;
    // zero divisor: every trial subtraction succeeds, so the whole
    // dividend magnitude ends up in rem_q and the sign fix above
    // restores the original dividend
    // only the quotient has to be forced
    if (b_zero_q) begin
      quo_out = '1;
    end
  end

  assign resp_result = {rem_out, quo_out};

endmodule

`default_nettype wire

/* src/int_div_iterative.sv */
/*
 * iterative integer divider, top level
 * joins the control FSM and the datapath
 */
`default_nettype none

module int_div_iterative #(
  parameter int WIDTH = imuldiv_pkg::DIV_WIDTH
) (
  input  logic                 clk,
  input  logic                 reset,

  // ----------------------------------------
  // request port
  // ----------------------------------------
  input  imuldiv_pkg::div_fn_e req_fn,
  input  logic [WIDTH-1:0]     req_a,
  input  logic [WIDTH-1:0]     req_b,
  input  logic                 req_val,
  output logic                 req_rdy,

  // ----------------------------------------
  // response port
  // ----------------------------------------
  // remainder in the upper half, quotient in the lower half
  output logic [2*WIDTH-1:0]   resp_result,
  output logic                 resp_val,
  input  logic                 resp_rdy
);

  // control to datapath
  logic load;
  logic step;

  // FSM, counter and handshake
  int_div_ctrl #(
    .WIDTH    (WIDTH)
  ) ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .load     (load),
    .step     (step)
  );

  // registers, restoring step and result correction
  int_div_dpath #(
    .WIDTH       (WIDTH)
  ) dpath (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .load        (load),
    .step        (step),
    .resp_result (resp_result)
  );

endmodule

`default_nettype wire

/* vlog.f */
src/imuldiv_pkg.sv
src/int_div_dpath.sv
src/int_div_ctrl.sv
src/int_div_iterative.sv
sim/div_props.sv
sim/div_checker.sv
sim/tb_int_div.sv
